//--- verilog/vga_params.svh
`ifndef VGA_PARAMS_SVH
`define VGA_PARAMS_SVH

////////////////////
// Horizontal frame timing, in pixel clocks
`define H_TOTAL       800
`define H_SYNC_END    95
`define H_DATA_BEGIN  143
`define H_DATA_END    783

////////////////////
// Vertical frame timing, in lines
`define V_TOTAL       525
`define V_SYNC_END    1
`define V_DATA_BEGIN  34
`define V_DATA_END    514

////////////////////
// Glyph row geometry, relative to the active area
`define NUM_DIGITS    6
`define DIGIT_LEFT0   99
`define DIGIT_PITCH   90
`define DIGIT_WIDTH   70

// Vertical band and stroke sizes
`define DIGIT_TOP     169
`define DIGIT_BOTTOM  309
`define DIGIT_MID     239
`define STROKE        16
`define HALF_STROKE   8

`endif

//--- verilog/vga_pkg.sv
`include "vga_params.svh"

package vga_pkg;

    ////////////////////
    // Pixel position and sync state
    typedef struct packed {
        logic [9:0] x;
        logic [8:0] y;
        logic       active;
        logic       hsync;
        logic       vsync;
    } pixel_pos_t;

    // 4 bits per color channel
    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb_t;

    // One BCD code per slot, slot 0 leftmost
    typedef logic [`NUM_DIGITS-1:0][3:0] digits_t;

    ////////////////////
    // Segment index into the lit mask
    typedef enum logic [2:0] {
        SEG_TOP         = 3'd0,
        SEG_UPPER_RIGHT = 3'd1,
        SEG_LOWER_RIGHT = 3'd2,
        SEG_BOTTOM      = 3'd3,
        SEG_LOWER_LEFT  = 3'd4,
        SEG_UPPER_LEFT  = 3'd5,
        SEG_MIDDLE      = 3'd6
    } seg_e;

    localparam int unsigned NUM_SEGS = 7;

    localparam rgb_t RGB_WHITE = '{r: 4'hf, g: 4'hf, b: 4'hf};
    localparam rgb_t RGB_BLACK = '{r: 4'h0, g: 4'h0, b: 4'h0};

endpackage

//--- verilog/vga_timing.sv
`include "vga_params.svh"

module vga_timing
    import vga_pkg::*;
(
    input  logic       vga_clk,
    input  logic       rst_n,
    output pixel_pos_t pix
);

    logic [9:0] h_cnt;
    logic [9:0] v_cnt;
    logic       h_wrap;
    logic       v_wrap;
    logic [9:0] h_off;
    logic [9:0] v_off;
    logic       in_window;

    assign h_wrap = (h_cnt == 10'(`H_TOTAL - 1));
    assign v_wrap = (v_cnt == 10'(`V_TOTAL - 1));

    ////////////////////
    // Frame counters
    always_ff @(posedge vga_clk)
    begin
        if (!rst_n)
        begin
            h_cnt <= '0;
            v_cnt <= '0;
        end
        else
        begin
            if (h_wrap)
                h_cnt <= '0;
            else
                h_cnt <= h_cnt + 10'd1;

            // Next line only at end of the current one
            if (h_wrap)
            begin
                if (v_wrap)
                    v_cnt <= '0;
                else
                    v_cnt <= v_cnt + 10'd1;
            end
        end
    end

    ////////////////////
    // Position and sync, one stage behind the counters
    assign h_off = h_cnt - 10'(`H_DATA_BEGIN);
    assign v_off = v_cnt - 10'(`V_DATA_BEGIN);

    assign in_window = (h_cnt >= 10'(`H_DATA_BEGIN)) && (h_cnt < 10'(`H_DATA_END)) &&
                       (v_cnt >= 10'(`V_DATA_BEGIN)) && (v_cnt < 10'(`V_DATA_END));

    always_ff @(posedge vga_clk)
    begin
        if (!rst_n)
        begin
            pix <= '{x: '0, y: '0, active: 1'b0, hsync: 1'b1, vsync: 1'b1};
        end
        else
        begin
            pix.x      <= h_off;
            pix.y      <= v_off[8:0];
            pix.active <= in_window;
            pix.hsync  <= (h_cnt > 10'(`H_SYNC_END));
            pix.vsync  <= (v_cnt > 10'(`V_SYNC_END));
        end
    end

    // Line counter stays inside one line period
    a_h_cnt_range: assert property (
        @(posedge vga_clk) disable iff (!rst_n)
        h_cnt < 10'(`H_TOTAL)
    );

endmodule

//--- verilog/digit_cell.sv
`include "vga_params.svh"

module digit_cell
    import vga_pkg::*;
#(
    parameter int unsigned SLOT = 0
)
(
    input  logic       vga_clk,
    input  logic       rst_n,
    input  logic [3:0] code,
    input  pixel_pos_t pix,
    output logic       hit
);

    localparam int unsigned LEFT   = `DIGIT_LEFT0 + SLOT * `DIGIT_PITCH;
    localparam int unsigned RIGHT  = LEFT + `DIGIT_WIDTH;
    localparam int unsigned MID_LO = `DIGIT_MID - `HALF_STROKE;
    localparam int unsigned MID_HI = `DIGIT_MID + `HALF_STROKE;

    logic [NUM_SEGS-1:0] lit;
    logic [NUM_SEGS-1:0] in_seg;

    logic in_x_full;
    logic in_x_left;
    logic in_x_right;
    logic in_y_top;
    logic in_y_bottom;
    logic in_y_mid;
    logic in_y_upper;
    logic in_y_lower;

    ////////////////////
    // Segment decode, bit order follows seg_e
    always_comb
    begin
        case (code)
            4'd0:    lit = 7'b0111111;
            4'd1:    lit = 7'b0000110;
            4'd2:    lit = 7'b1011011;
            4'd3:    lit = 7'b1001111;
            4'd4:    lit = 7'b1100110;
            4'd5:    lit = 7'b1101101;
            4'd6:    lit = 7'b1111101;
            4'd7:    lit = 7'b0000111;
            4'd8:    lit = 7'b1111111;
            4'd9:    lit = 7'b1101111;
            // Blank cell
            default: lit = 7'b0000000;
        endcase
    end

    ////////////////////
    // Stripes, lower bound open and upper bound closed
    assign in_x_full  = (pix.x > LEFT) && (pix.x <= RIGHT);
    assign in_x_left  = (pix.x > LEFT) && (pix.x <= LEFT + `STROKE);
    assign in_x_right = (pix.x > RIGHT - `STROKE) && (pix.x <= RIGHT);

    assign in_y_top    = (pix.y > `DIGIT_TOP) && (pix.y <= `DIGIT_TOP + `STROKE);
    assign in_y_bottom = (pix.y > `DIGIT_BOTTOM - `STROKE) && (pix.y <= `DIGIT_BOTTOM);
    assign in_y_mid    = (pix.y > MID_LO) && (pix.y <= MID_HI);
    assign in_y_upper  = (pix.y > `DIGIT_TOP) && (pix.y <= MID_HI);
    assign in_y_lower  = (pix.y > MID_LO) && (pix.y <= `DIGIT_BOTTOM);

    // Rectangles per segment
    always_comb
    begin
        in_seg                  = '0;
        in_seg[SEG_TOP]         = in_x_full  && in_y_top;
        in_seg[SEG_BOTTOM]      = in_x_full  && in_y_bottom;
        in_seg[SEG_MIDDLE]      = in_x_full  && in_y_mid;
        in_seg[SEG_UPPER_LEFT]  = in_x_left  && in_y_upper;
        in_seg[SEG_LOWER_LEFT]  = in_x_left  && in_y_lower;
        in_seg[SEG_UPPER_RIGHT] = in_x_right && in_y_upper;
        in_seg[SEG_LOWER_RIGHT] = in_x_right && in_y_lower;
    end

    always_ff @(posedge vga_clk)
    begin
        if (!rst_n)
            hit <= 1'b0;
        else
            hit <= |(lit & in_seg);
    end

    // Out of range codes never light the next pixel
    a_blank_code: assert property (
        @(posedge vga_clk) disable iff (!rst_n)
        (code > 4'd9) |=> !hit
    );

endmodule

//--- verilog/pixel_mixer.sv
`include "vga_params.svh"

module pixel_mixer
    import vga_pkg::*;
(
    input  logic                   vga_clk,
    input  logic                   rst_n,
    input  pixel_pos_t             pix,
    input  logic [`NUM_DIGITS-1:0] hits,
    output rgb_t                   rgb,
    output logic                   hsync,
    output logic                   vsync
);

    pixel_pos_t pix_d;
    logic       any_hit;

    ////////////////////
    // Match the cell stage
    always_ff @(posedge vga_clk)
    begin
        if (!rst_n)
            pix_d <= '{x: '0, y: '0, active: 1'b0, hsync: 1'b1, vsync: 1'b1};
        else
            pix_d <= pix;
    end

    assign any_hit = |hits;

    ////////////////////
    // Output stage
    always_ff @(posedge vga_clk)
    begin
        if (!rst_n)
        begin
            rgb   <= RGB_BLACK;
            hsync <= 1'b1;
            vsync <= 1'b1;
        end
        else
        begin
            // Blanking outside the data window
            if (pix_d.active && any_hit)
                rgb <= RGB_WHITE;
            else
                rgb <= RGB_BLACK;
            hsync <= pix_d.hsync;
            vsync <= pix_d.vsync;
        end
    end

    a_blank_inactive: assert property (
        @(posedge vga_clk) disable iff (!rst_n)
        !pix_d.active |=> (rgb == RGB_BLACK)
    );

endmodule

//--- verilog/digit_display_top.sv
`include "vga_params.svh"

module digit_display_top
    import vga_pkg::*;
(
    input  logic    vga_clk,
    input  logic    rst_n,
    input  digits_t digits,
    output rgb_t    rgb,
    output logic    hsync,
    output logic    vsync
);

    pixel_pos_t             pix;
    logic [`NUM_DIGITS-1:0] hits;

    vga_timing i_timing (
        .vga_clk (vga_clk),
        .rst_n   (rst_n),
        .pix     (pix)
    );

    ////////////////////
    // One cell per digit slot
    for (genvar i = 0; i < `NUM_DIGITS; i++)
    begin : g_cell
        digit_cell #(
            .SLOT (i)
        ) i_cell (
            .vga_clk (vga_clk),
            .rst_n   (rst_n),
            .code    (digits[i]),
            .pix     (pix),
            .hit     (hits[i])
        );
    end

    pixel_mixer i_mixer (
        .vga_clk (vga_clk),
        .rst_n   (rst_n),
        .pix     (pix),
        .hits    (hits),
        .rgb     (rgb),
        .hsync   (hsync),
        .vsync   (vsync)
    );

endmodule

//--- testbench/tb_digit_display.sv
`include "vga_params.svh"

module tb_digit_display
    import vga_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_FRAMES  = 4;
    localparam int FRAME_TICKS = `H_TOTAL * `V_TOTAL;

    logic        vga_clk;
    logic        rst_n;
    digits_t     digits;
    rgb_t        rgb;
    logic        hsync;
    logic        vsync;
    logic [31:0] lfsr;

    digit_display_top i_dut (
        .vga_clk (vga_clk),
        .rst_n   (rst_n),
        .digits  (digits),
        .rgb     (rgb),
        .hsync   (hsync),
        .vsync   (vsync)
    );

    initial
    begin
        vga_clk = 1'b0;
        forever #4 vga_clk = ~vga_clk;
    end

    ////////////////////
    // Helpers
    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected)
        begin
            $display("ERROR: time %0t signal %s actual %0h expected %0h",
                     $time, name, actual, expected);
            $display("TEST FAIL");
            $fatal(1);
        end
    endtask

    task automatic timeout_fail(input string what);
        $display("Timeout: %s", what);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    // Galois form, right shift
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        if (state[0])
            return (state >> 1) ^ 32'hb4bc_d35c;
        return state >> 1;
    endfunction

    task automatic draw_code(input bit blank, output logic [3:0] code);
        logic [3:0] raw;
        int         i;
        raw = '0;
        for (i = 0; i < 4; i++)
        begin
            lfsr = lfsr_step(lfsr);
            raw  = {raw[2:0], lfsr[0]};
        end
        code = blank ? 4'(10 + raw % 6) : 4'(raw % 10);
    endtask

    function automatic bit in_span(input int val, input int lo, input int hi);
        return (val > lo) && (val <= hi);
    endfunction

    ////////////////////
    // Reference pixel
    function automatic rgb_t expected_rgb(input int h, input int v, input digits_t codes);
        int x;
        int y;
        int k;
        int left;
        int right;
        bit fx, lx, rx;
        bit top, bottom, middle, up_l, lo_l, up_r, lo_r;
        bit on;
        on = 1'b0;
        if (h < `H_DATA_BEGIN || h >= `H_DATA_END || v < `V_DATA_BEGIN || v >= `V_DATA_END)
            return rgb_t'(12'h000);
        x = h - `H_DATA_BEGIN;
        y = v - `V_DATA_BEGIN;
        for (k = 0; k < `NUM_DIGITS; k++)
        begin
            left   = 99 + 90 * k;
            right  = left + 70;
            fx     = in_span(x, left, right);
            lx     = in_span(x, left, left + 16);
            rx     = in_span(x, right - 16, right);
            top    = fx && in_span(y, 169, 185);
            bottom = fx && in_span(y, 293, 309);
            middle = fx && in_span(y, 231, 247);
            up_l   = lx && in_span(y, 169, 247);
            lo_l   = lx && in_span(y, 231, 309);
            up_r   = rx && in_span(y, 169, 247);
            lo_r   = rx && in_span(y, 231, 309);
            case (codes[k])
                4'd0: on |= top | bottom | up_l | lo_l | up_r | lo_r;
                4'd1: on |= up_r | lo_r;
                4'd2: on |= top | up_r | middle | lo_l | bottom;
                4'd3: on |= top | up_r | lo_r | middle | bottom;
                4'd4: on |= up_l | up_r | middle | lo_r;
                4'd5: on |= top | up_l | middle | lo_r | bottom;
                4'd6: on |= top | bottom | middle | up_l | lo_l | lo_r;
                4'd7: on |= top | up_r | lo_r;
                4'd8: on |= top | bottom | middle | up_l | lo_l | up_r | lo_r;
                4'd9: on |= top | bottom | middle | up_l | up_r | lo_r;
                default: on |= 1'b0;
            endcase
        end
        return on ? rgb_t'(12'hfff) : rgb_t'(12'h000);
    endfunction

    task automatic wait_vsync_fall(input int limit);
        int   cycles;
        logic prev;
        cycles = 0;
        prev   = vsync;
        @(posedge vga_clk);
        while (!(prev === 1'b1 && vsync === 1'b0))
        begin
            prev = vsync;
            cycles++;
            if (cycles > limit)
                timeout_fail("vsync never toggled");
            @(posedge vga_clk);
        end
    endtask

    ////////////////////
    // Compare process
    initial
    begin : compare
        int   h;
        int   v;
        int   cycles;
        rgb_t exp_rgb;
        cycles = 0;
        // First edge only loads the reset values
        @(posedge vga_clk);
        @(posedge vga_clk);
        while (hsync !== 1'b0)
        begin
            check_value("hsync", hsync, 1);
            check_value("vsync", vsync, 1);
            check_value("rgb", rgb, 0);
            cycles++;
            if (cycles > 64)
                timeout_fail("hsync never toggled after reset");
            @(posedge vga_clk);
        end
        h = 0;
        v = 0;
        forever
        begin
            exp_rgb = expected_rgb(h, v, digits);
            check_value("hsync", hsync, (h > `H_SYNC_END));
            check_value("vsync", vsync, (v > `V_SYNC_END));
            check_value("rgb", rgb, exp_rgb);
            @(posedge vga_clk);
            h++;
            if (h == `H_TOTAL)
            begin
                h = 0;
                v = (v == `V_TOTAL - 1) ? 0 : v + 1;
            end
        end
    end

    ////////////////////
    // Stimulus
    initial
    begin : stimulus
        digits_t next_digits;
        int      frame;
        int      k;
        rst_n      = 1'b0;
        digits     = '0;
        lfsr       = 32'd69256;
        repeat (10) @(posedge vga_clk);
        rst_n <= 1'b1;
        for (frame = 0; frame < NUM_FRAMES; frame++)
        begin
            wait_vsync_fall(FRAME_TICKS + 100);
            // Every third frame shows blank codes only
            for (k = 0; k < `NUM_DIGITS; k++)
                draw_code(frame % 3 == 2, next_digits[k]);
            digits <= next_digits;
        end
        wait_vsync_fall(FRAME_TICKS + 100);
        $display("TEST PASS");
        $finish;
    end

endmodule

//--- flist.f
+incdir+verilog
verilog/vga_pkg.sv
verilog/vga_timing.sv
verilog/digit_cell.sv
verilog/pixel_mixer.sv
verilog/digit_display_top.sv
testbench/tb_digit_display.sv
